//--- hdl/adder.sv
`timescale 1ns/100ps

module adder (
   input  logic                            ci,
   input  logic [exec_pkg::data_width-1:0] ai,
   input  logic [exec_pkg::data_width-1:0] bi,
   output logic [exec_pkg::data_width-1:0] res,
   output logic                            co,
   output logic                            vo
);

   logic [exec_pkg::data_width:0] sum;

   // one extra bit catches the carry out
   assign sum = {1'b0, ai} + {1'b0, bi} + {{exec_pkg::data_width{1'b0}}, ci};

   assign res = sum[exec_pkg::data_width-1:0];
   assign co  = sum[exec_pkg::data_width];

   // same operand signs, different result sign
   assign vo = (ai[exec_pkg::data_width-1] == bi[exec_pkg::data_width-1]) &&
               (res[exec_pkg::data_width-1] != ai[exec_pkg::data_width-1]);

endmodule

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu (
   exec_if.arith                            bus,
   output logic [exec_pkg::data_width-1:0]  res,
   output logic [exec_pkg::flag_count-1:0]  flags
);

   logic                                ci;
   logic                                vi;
   logic                                zi;
   logic                                si;
   logic                                cin;
   logic [exec_pkg::data_width-1:0]     op2;
   logic [exec_pkg::data_width-1:0]     ares;
   logic                                aco;
   logic                                avo;
   logic [2*exec_pkg::data_width-1:0]   mres;
   logic                                co;
   logic                                cls_arith;
   logic                                cls_carry;

   assign ci = bus.flags[exec_pkg::flag_c];
   assign vi = bus.flags[exec_pkg::flag_v];
   assign zi = bus.flags[exec_pkg::flag_z];
   assign si = bus.flags[exec_pkg::flag_s];

   // carry in and second operand per opcode
   always_comb begin
      cin = ci;
      op2 = bus.b;
      case (bus.op)
         exec_pkg::op_add: cin = 1'b0;
         exec_pkg::op_sub,
         exec_pkg::op_cmp: begin
            cin = 1'b1;
            op2 = ~bus.b;
         end
         exec_pkg::op_sbb: op2 = ~bus.b;
         exec_pkg::op_inc: begin
            cin = 1'b1;
            op2 = '0;
         end
         exec_pkg::op_dec: begin
            cin = 1'b0;
            op2 = '1;
         end
         default: ;
      endcase
   end

   adder i_adder (
      .ci  (cin),
      .ai  (bus.a),
      .bi  (op2),
      .res (ares),
      .co  (aco),
      .vo  (avo)
   );

   assign mres = bus.a * bus.b;

   // result and carry out
   always_comb begin
      res = bus.a;
      co  = ci;
      case (bus.op)
         exec_pkg::op_add, exec_pkg::op_adc, exec_pkg::op_sub, exec_pkg::op_sbb,
         exec_pkg::op_inc, exec_pkg::op_dec, exec_pkg::op_cmp: begin
            res = ares;
            co  = aco;
         end
         exec_pkg::op_and: res = bus.a & bus.b;
         exec_pkg::op_or:  res = bus.a | bus.b;
         exec_pkg::op_xor: res = bus.a ^ bus.b;
         exec_pkg::op_shl: begin
            res = {bus.a[exec_pkg::data_width-2:0], 1'b0};
            co  = bus.a[exec_pkg::data_width-1];
         end
         exec_pkg::op_shr: begin
            res = {1'b0, bus.a[exec_pkg::data_width-1:1]};
            co  = bus.a[0];
         end
         exec_pkg::op_sha: begin
            res = {bus.a[exec_pkg::data_width-1], bus.a[exec_pkg::data_width-1:1]};
            co  = bus.a[0];
         end
         // rotates go through the carry
         exec_pkg::op_rol: begin
            res = {bus.a[exec_pkg::data_width-2:0], ci};
            co  = bus.a[exec_pkg::data_width-1];
         end
         exec_pkg::op_ror: begin
            res = {ci, bus.a[exec_pkg::data_width-1:1]};
            co  = bus.a[0];
         end
         exec_pkg::op_mul: res = mres[exec_pkg::data_width-1:0];
         exec_pkg::op_muh: res = mres[2*exec_pkg::data_width-1:exec_pkg::data_width];
         exec_pkg::op_stc: co = 1'b1;
         exec_pkg::op_clc: co = 1'b0;
         default: ;
      endcase
   end

   // opcode classes for the flag rules
   assign cls_arith = (bus.op == exec_pkg::op_add) || (bus.op == exec_pkg::op_adc) ||
                      (bus.op == exec_pkg::op_sub) || (bus.op == exec_pkg::op_sbb) ||
                      (bus.op == exec_pkg::op_inc) || (bus.op == exec_pkg::op_dec) ||
                      (bus.op == exec_pkg::op_cmp) || (bus.op == exec_pkg::op_mul) ||
                      (bus.op == exec_pkg::op_muh) || (bus.op == exec_pkg::op_div);
   assign cls_carry = (bus.op == exec_pkg::op_stc) || (bus.op == exec_pkg::op_clc);

   always_comb begin
      flags                   = '0;
      flags[exec_pkg::flag_c] = co;
      flags[exec_pkg::flag_v] = cls_arith ? avo : vi;
      flags[exec_pkg::flag_z] = cls_carry ? zi : ~|res;
      flags[exec_pkg::flag_s] = cls_arith ? res[exec_pkg::data_width-1] : si;
   end

endmodule

//--- hdl/divider.sv
`timescale 1ns/100ps

module divider (
   input  logic                            clk,
   input  logic                            reset,
   exec_if.div                             bus,
   output logic [exec_pkg::data_width-1:0] quotient,
   output logic                            div_zero,
   output logic                            done
);

   logic [exec_pkg::data_width-1:0] rem;
   logic [exec_pkg::data_width-1:0] q;
   logic [exec_pkg::data_width-1:0] divisor;
   logic [exec_pkg::div_steps-1:0]  step_sr;
   logic [exec_pkg::data_width+1:0] trial;
   logic                            busy;

   // one-hot step counter, a set bit means an iteration this cycle
   assign busy = |step_sr;

   always_ff @(posedge clk) begin
      if (reset) begin
         step_sr <= '0;
         done    <= 1'b0;
      end else begin
         done <= step_sr[exec_pkg::div_steps-1];
         if (bus.start) begin
            step_sr <= {{(exec_pkg::div_steps-1){1'b0}}, 1'b1};
         end else begin
            step_sr <= step_sr << 1;
         end
      end
   end

   // shifted partial remainder minus divisor, msb set when negative
   assign trial = {1'b0, rem, q[exec_pkg::data_width-1]} - {2'b00, divisor};

   always_ff @(posedge clk) begin
      if (bus.start) begin
         rem      <= '0;
         q        <= bus.a;
         divisor  <= bus.b;
         div_zero <= (bus.b == '0);
      end else if (busy) begin
         q <= {q[exec_pkg::data_width-2:0], ~trial[exec_pkg::data_width+1]};
         if (!trial[exec_pkg::data_width+1]) begin
            rem <= trial[exec_pkg::data_width-1:0];
         end else begin
            // restore
            rem <= {rem[exec_pkg::data_width-2:0], q[exec_pkg::data_width-1]};
         end
      end
   end

   // all ones on a zero divisor
   assign quotient = div_zero ? '1 : q;

endmodule

//--- hdl/exec_control.sv
`timescale 1ns/100ps

module exec_control (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            req,
   input  logic [exec_pkg::op_width-1:0]   op,
   input  logic [exec_pkg::data_width-1:0] a,
   input  logic [exec_pkg::data_width-1:0] b,
   output logic                            ack,
   output logic [exec_pkg::data_width-1:0] res,
   output logic [exec_pkg::flag_count-1:0] flags,
   exec_if.ctrl                            bus,
   input  logic [exec_pkg::data_width-1:0] alu_res,
   input  logic [exec_pkg::flag_count-1:0] alu_flags,
   input  logic [exec_pkg::data_width-1:0] quotient,
   input  logic                            div_zero,
   input  logic                            div_done
);

   typedef enum logic [1:0] {
      s_idle,
      s_wait,
      s_ack,
      s_release
   } state_t;

   state_t                          state;
   logic [exec_pkg::flag_count-1:0] div_flags;

   assign bus.flags = flags;

   // divide keeps carry and sign
   always_comb begin
      div_flags                   = flags;
      div_flags[exec_pkg::flag_v] = div_zero;
      div_flags[exec_pkg::flag_z] = ~|quotient;
   end

   // operation latch, taken on acceptance
   always_ff @(posedge clk) begin
      if (state == s_idle && req) begin
         bus.op <= op;
         bus.a  <= a;
         bus.b  <= b;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= s_idle;
         ack       <= 1'b0;
         bus.start <= 1'b0;
         res       <= '0;
         flags     <= '0;
      end else begin
         bus.start <= 1'b0;
         case (state)
            s_idle: begin
               if (req) begin
                  bus.start <= (op == exec_pkg::op_div);
                  state     <= s_wait;
               end
            end
            // alu ops finish here in one cycle
            s_wait: begin
               if (bus.op != exec_pkg::op_div) begin
                  res   <= alu_res;
                  flags <= alu_flags;
                  ack   <= 1'b1;
                  state <= s_ack;
               end else if (div_done) begin
                  res   <= quotient;
                  flags <= div_flags;
                  ack   <= 1'b1;
                  state <= s_ack;
               end
            end
            s_ack: begin
               if (!req) begin
                  state <= s_release;
               end
            end
            s_release: begin
               ack   <= 1'b0;
               state <= s_idle;
            end
            default: state <= s_idle;
         endcase
      end
   end

endmodule

//--- hdl/exec_if.sv
`timescale 1ns/100ps

interface exec_if;

   // operation held stable while the ALU and divider work on it
   logic [exec_pkg::op_width-1:0]   op;
   logic [exec_pkg::data_width-1:0] a;
   logic [exec_pkg::data_width-1:0] b;

   // current flag register, feeds carry-in and unchanged flags
   logic [exec_pkg::flag_count-1:0] flags;

   // one-cycle pulse, kicks off a divide
   logic                            start;

   modport ctrl (
      output op,
      output a,
      output b,
      output flags,
      output start
   );

   modport arith (
      input op,
      input a,
      input b,
      input flags
   );

   modport div (
      input a,
      input b,
      input start
   );

endinterface

//--- hdl/exec_pkg.sv
package exec_pkg;

   // operand and result width
   localparam int data_width = 8;
   localparam int op_width   = 5;

   // opcodes
   localparam logic [op_width-1:0] op_add = 5'd0;
   localparam logic [op_width-1:0] op_adc = 5'd1;
   localparam logic [op_width-1:0] op_sub = 5'd2;
   localparam logic [op_width-1:0] op_sbb = 5'd3;
   localparam logic [op_width-1:0] op_inc = 5'd4;
   localparam logic [op_width-1:0] op_dec = 5'd5;
   localparam logic [op_width-1:0] op_and = 5'd6;
   localparam logic [op_width-1:0] op_or  = 5'd7;
   localparam logic [op_width-1:0] op_xor = 5'd8;
   localparam logic [op_width-1:0] op_shl = 5'd9;
   localparam logic [op_width-1:0] op_shr = 5'd10;
   localparam logic [op_width-1:0] op_rol = 5'd11;
   localparam logic [op_width-1:0] op_ror = 5'd12;
   localparam logic [op_width-1:0] op_mul = 5'd13;
   localparam logic [op_width-1:0] op_div = 5'd14;
   localparam logic [op_width-1:0] op_cmp = 5'd15;
   localparam logic [op_width-1:0] op_sha = 5'd16;
   localparam logic [op_width-1:0] op_stc = 5'd17;
   localparam logic [op_width-1:0] op_clc = 5'd18;
   localparam logic [op_width-1:0] op_muh = 5'd19;

   // bit positions in the flag vector
   localparam int flag_c     = 0;
   localparam int flag_v     = 1;
   localparam int flag_z     = 2;
   localparam int flag_s     = 3;
   localparam int flag_count = 4;

   // one quotient bit per iteration
   localparam int div_steps = data_width;

endpackage

//--- hdl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            req,
   input  logic [exec_pkg::op_width-1:0]   op,
   input  logic [exec_pkg::data_width-1:0] a,
   input  logic [exec_pkg::data_width-1:0] b,
   output logic                            ack,
   output logic [exec_pkg::data_width-1:0] res,
   output logic [exec_pkg::flag_count-1:0] flags
);

   logic [exec_pkg::data_width-1:0] alu_res;
   logic [exec_pkg::flag_count-1:0] alu_flags;
   logic [exec_pkg::data_width-1:0] quotient;
   logic                            div_zero;
   logic                            div_done;

   exec_if bus ();

   exec_control i_control (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .op        (op),
      .a         (a),
      .b         (b),
      .ack       (ack),
      .res       (res),
      .flags     (flags),
      .bus       (bus.ctrl),
      .alu_res   (alu_res),
      .alu_flags (alu_flags),
      .quotient  (quotient),
      .div_zero  (div_zero),
      .div_done  (div_done)
   );

   alu i_alu (
      .bus   (bus.arith),
      .res   (alu_res),
      .flags (alu_flags)
   );

   divider i_divider (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus.div),
      .quotient (quotient),
      .div_zero (div_zero),
      .done     (div_done)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the exec_unit testbench with Verilator, then judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module exec_unit_tb -f verilog.f -o exec_unit_sim \
   && ./obj_dir/exec_unit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0

//--- verification/exec_unit_chk.sv
`timescale 1ns/100ps

module exec_unit_chk (
   input logic clk,
   input logic reset,
   input logic req,
   input logic ack,
   input logic start
);

   // ack only answers a pending req
   ack_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack) |-> $past(req))
      else $error("ack rose while req was low");

   quiet_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> (!ack && !start))
      else $error("ack or start high right after reset");

   start_is_pulse: assert property (@(posedge clk) disable iff (reset)
      start |=> !start)
      else $error("divide start held longer than one cycle");

endmodule

bind exec_control exec_unit_chk i_chk (
   .clk   (clk),
   .reset (reset),
   .req   (req),
   .ack   (ack),
   .start (bus.start)
);

//--- verification/exec_unit_monitor.sv
`timescale 1ns/100ps

module exec_unit_monitor (
   input  logic       clk,
   input  logic       reset,
   input  logic       req,
   input  logic [4:0] op,
   input  logic [7:0] a,
   input  logic [7:0] b,
   input  logic       ack,
   input  logic [7:0] res,
   input  logic [3:0] flags,
   output int         errors
);

   logic [4:0]  op_q;
   logic [7:0]  a_q;
   logic [7:0]  b_q;
   logic [3:0]  model_flags;
   logic [7:0]  held_res;
   logic [3:0]  held_flags;
   logic [11:0] expected;
   logic        req_d;
   logic        ack_d;
   int          req_gap;
   int          drop_gap;
   int          err_count = 0;

   assign errors = err_count;

   // expected {flags, res} for one operation
   function automatic logic [11:0] expect_result(
      input logic [4:0] op_i,
      input logic [7:0] a_i,
      input logic [7:0] b_i,
      input logic [3:0] f_i
   );
      logic [3:0]  f;
      logic [7:0]  r;
      logic [8:0]  wide;
      logic [15:0] prod;
      logic        c_in;
      logic        borrow;
      f      = f_i;
      r      = a_i;
      c_in   = f_i[exec_pkg::flag_c];
      borrow = (op_i == exec_pkg::op_sbb) ? !c_in : 1'b0;
      prod   = {8'd0, a_i} * {8'd0, b_i};
      case (op_i)
         exec_pkg::op_add, exec_pkg::op_adc, exec_pkg::op_mul, exec_pkg::op_muh: begin
            // mul and muh still report the overflow of a + b + c
            wide = {1'b0, a_i} + {1'b0, b_i} + {8'd0, (c_in && op_i != exec_pkg::op_add)};
            f[exec_pkg::flag_v] = (a_i[7] == b_i[7]) && (wide[7] != a_i[7]);
            if (op_i == exec_pkg::op_mul) begin
               r = prod[7:0];
            end else if (op_i == exec_pkg::op_muh) begin
               r = prod[15:8];
            end else begin
               r = wide[7:0];
               f[exec_pkg::flag_c] = wide[8];
            end
            f[exec_pkg::flag_s] = r[7];
         end
         exec_pkg::op_sub, exec_pkg::op_sbb, exec_pkg::op_cmp: begin
            wide = {1'b0, a_i} - {1'b0, b_i} - {8'd0, borrow};
            r    = wide[7:0];
            // carry means no borrow
            f[exec_pkg::flag_c] = !wide[8];
            f[exec_pkg::flag_v] = (a_i[7] != b_i[7]) && (r[7] != a_i[7]);
            f[exec_pkg::flag_s] = r[7];
         end
         exec_pkg::op_inc, exec_pkg::op_dec: begin
            r = (op_i == exec_pkg::op_inc) ? a_i + 8'd1 : a_i - 8'd1;
            f[exec_pkg::flag_c] = (op_i == exec_pkg::op_inc) ? (a_i == 8'hff) : (a_i != 8'h00);
            f[exec_pkg::flag_v] = (op_i == exec_pkg::op_inc) ? (a_i == 8'h7f) : (a_i == 8'h80);
            f[exec_pkg::flag_s] = r[7];
         end
         exec_pkg::op_and: r = a_i & b_i;
         exec_pkg::op_or:  r = a_i | b_i;
         exec_pkg::op_xor: r = a_i ^ b_i;
         exec_pkg::op_shl, exec_pkg::op_rol: begin
            r = {a_i[6:0], (op_i == exec_pkg::op_rol) ? c_in : 1'b0};
            f[exec_pkg::flag_c] = a_i[7];
         end
         exec_pkg::op_shr, exec_pkg::op_sha, exec_pkg::op_ror: begin
            r = a_i >> 1;
            if (op_i == exec_pkg::op_sha) begin
               r[7] = a_i[7];
            end else if (op_i == exec_pkg::op_ror) begin
               r[7] = c_in;
            end
            f[exec_pkg::flag_c] = a_i[0];
         end
         exec_pkg::op_stc: f[exec_pkg::flag_c] = 1'b1;
         exec_pkg::op_clc: f[exec_pkg::flag_c] = 1'b0;
         exec_pkg::op_div: begin
            r = (b_i == 8'h00) ? 8'hff : a_i / b_i;
            f[exec_pkg::flag_v] = (b_i == 8'h00);
         end
         default: ;
      endcase
      if (op_i != exec_pkg::op_stc && op_i != exec_pkg::op_clc) begin
         f[exec_pkg::flag_z] = (r == 8'h00);
      end
      return {f, r};
   endfunction

   // sampled at the edge, so the DUT takes req at the edge it is first seen
   // and ack set at the following edge shows up one edge later
   always @(posedge clk) begin
      if (reset) begin
         model_flags = '0;
         req_gap     = 0;
         drop_gap    = 0;
      end else begin
         if (req && !req_d) begin
            op_q    = op;
            a_q     = a;
            b_q     = b;
            req_gap = 0;
         end else begin
            req_gap++;
         end
         if (!req && req_d) begin
            drop_gap = 0;
         end else begin
            drop_gap++;
         end
         if (ack && !ack_d) begin
            expected = expect_result(op_q, a_q, b_q, model_flags);
            if (res !== expected[7:0]) begin
               $display("MISMATCH res: got %h expected %h (op %0d a %h b %h)",
                        res, expected[7:0], op_q, a_q, b_q);
               err_count++;
            end
            if (flags !== expected[11:8]) begin
               $display("MISMATCH flags: got %h expected %h (op %0d a %h b %h)",
                        flags, expected[11:8], op_q, a_q, b_q);
               err_count++;
            end
            if (op_q != exec_pkg::op_div && req_gap != 2) begin
               $display("ERROR: ack rose %0d cycles after req instead of 1", req_gap - 1);
               err_count++;
            end
            model_flags = expected[11:8];
            held_res    = res;
            held_flags  = flags;
         end else if (ack && ack_d) begin
            if (res !== held_res) begin
               $display("MISMATCH res: moved from %h to %h while ack held", held_res, res);
               err_count++;
            end
            if (flags !== held_flags) begin
               $display("MISMATCH flags: moved from %h to %h while ack held", held_flags, flags);
               err_count++;
            end
         end else if (!ack && ack_d) begin
            if (drop_gap != 2) begin
               $display("ERROR: ack fell %0d cycles after req dropped instead of 1",
                        drop_gap - 1);
               err_count++;
            end
         end else if (flags !== model_flags) begin
            $display("MISMATCH flags: got %h expected %h with no ack", flags, model_flags);
            err_count++;
         end
      end
      req_d = req;
      ack_d = ack;
   end

endmodule

//--- verification/exec_unit_tb.sv
`timescale 1ns/100ps

module exec_unit_tb;

   localparam int clk_period     = 40;
   localparam int op_budget      = 400;
   localparam int timeout_cycles = op_budget * (exec_pkg::div_steps + 6);

   logic        clk;
   logic        reset;
   logic        req;
   logic [4:0]  op;
   logic [7:0]  a;
   logic [7:0]  b;
   logic        ack;
   logic [7:0]  res;
   logic [3:0]  flags;
   logic [31:0] lcg_state;
   int          mon_errors;
   int          tb_errors = 0;

   exec_unit i_dut (
      .clk   (clk),
      .reset (reset),
      .req   (req),
      .op    (op),
      .a     (a),
      .b     (b),
      .ack   (ack),
      .res   (res),
      .flags (flags)
   );

   exec_unit_monitor i_monitor (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .op     (op),
      .a      (a),
      .b      (b),
      .ack    (ack),
      .res    (res),
      .flags  (flags),
      .errors (mon_errors)
   );

   always #(clk_period / 2) clk = ~clk;

   function automatic logic [7:0] next_byte();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];
   endfunction

   // one full four-phase transfer, req held for hold cycles after ack
   task automatic run_op(
      input logic [4:0] op_i,
      input logic [7:0] a_i,
      input logic [7:0] b_i,
      input int         hold
   );
      @(posedge clk);
      #2;
      op  = op_i;
      a   = a_i;
      b   = b_i;
      req = 1'b1;
      do begin
         @(posedge clk);
         #2;
      end while (!ack);
      // operands are free once ack is seen
      repeat (hold) begin
         a = next_byte();
         b = next_byte();
         @(posedge clk);
         #2;
      end
      req = 1'b0;
      do begin
         @(posedge clk);
         #2;
      end while (ack);
   endtask

   task automatic finish_run();
      $display("closing: %0d errors (%0d from monitor, %0d from testbench)",
               mon_errors + tb_errors, mon_errors, tb_errors);
      if (mon_errors + tb_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   endtask

   // watchdog
   initial begin
      #(timeout_cycles * clk_period);
      $display("ERROR: ack never arrived, run stopped after %0d cycles", timeout_cycles);
      tb_errors++;
      finish_run();
   end

   initial begin
      logic [7:0] x;
      logic [7:0] y;
      logic [7:0] r;
      clk       = 1'b0;
      reset     = 1'b1;
      req       = 1'b0;
      op        = '0;
      a         = '0;
      b         = '0;
      lcg_state = 32'd95;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;

      // arithmetic, carry chains through the flags
      run_op(exec_pkg::op_clc, 8'h00, 8'h00, 0);
      run_op(exec_pkg::op_add, 8'h7f, 8'h01, 0);
      run_op(exec_pkg::op_add, 8'hff, 8'h01, 0);
      run_op(exec_pkg::op_adc, 8'h10, 8'h20, 0);
      run_op(exec_pkg::op_sub, 8'h00, 8'h01, 0);
      run_op(exec_pkg::op_sbb, 8'h05, 8'h03, 0);
      run_op(exec_pkg::op_sbb, 8'h05, 8'h03, 0);
      run_op(exec_pkg::op_inc, 8'hff, 8'h00, 0);
      run_op(exec_pkg::op_inc, 8'h7f, 8'h00, 0);
      run_op(exec_pkg::op_dec, 8'h00, 8'h00, 0);
      run_op(exec_pkg::op_dec, 8'h80, 8'h00, 0);
      run_op(exec_pkg::op_cmp, 8'h42, 8'h42, 0);
      run_op(exec_pkg::op_cmp, 8'h7f, 8'hff, 0);

      // logic, shifts and rotates through carry
      run_op(exec_pkg::op_and, 8'hf0, 8'h3c, 0);
      run_op(exec_pkg::op_or,  8'h00, 8'h00, 0);
      run_op(exec_pkg::op_xor, 8'h5a, 8'h5a, 0);
      run_op(exec_pkg::op_stc, 8'h00, 8'h00, 0);
      run_op(exec_pkg::op_rol, 8'h80, 8'h00, 0);
      run_op(exec_pkg::op_ror, 8'h01, 8'h00, 0);
      run_op(exec_pkg::op_shl, 8'h81, 8'h00, 0);
      run_op(exec_pkg::op_shr, 8'h01, 8'h00, 0);
      run_op(exec_pkg::op_sha, 8'h80, 8'h00, 0);
      run_op(exec_pkg::op_clc, 8'h00, 8'h00, 0);
      run_op(exec_pkg::op_rol, 8'h80, 8'h00, 0);
      run_op(exec_pkg::op_ror, 8'h01, 8'h00, 0);

      for (int i = 0; i < 8; i++) begin
         x = next_byte();
         y = next_byte();
         run_op(exec_pkg::op_mul, x, y, 0);
         run_op(exec_pkg::op_muh, x, y, 0);
      end

      // divides, random then corner cases
      for (int i = 0; i < 8; i++) begin
         x = next_byte();
         y = next_byte();
         run_op(exec_pkg::op_div, x, y, 0);
      end
      run_op(exec_pkg::op_div, 8'h37, 8'h00, 0);
      run_op(exec_pkg::op_div, 8'h00, 8'h00, 0);
      run_op(exec_pkg::op_div, 8'h03, 8'hc8, 0);
      run_op(exec_pkg::op_div, 8'hff, 8'h01, 0);

      // req held well past ack
      run_op(exec_pkg::op_add, 8'h12, 8'h34, 6);
      run_op(exec_pkg::op_div, 8'h90, 8'h07, 5);
      run_op(exec_pkg::op_xor, 8'haa, 8'h55, 3);

      for (int i = 0; i < 300; i++) begin
         r = next_byte();
         x = next_byte();
         y = next_byte();
         run_op(r[4:0], x, y, int'(r[7:6]));
      end

      repeat (4) @(posedge clk);
      finish_run();
   end

endmodule

//--- verilog.f
hdl/exec_pkg.sv
hdl/exec_if.sv
hdl/adder.sv
hdl/alu.sv
hdl/divider.sv
hdl/exec_control.sv
hdl/exec_unit.sv
verification/exec_unit_chk.sv
verification/exec_unit_monitor.sv
verification/exec_unit_tb.sv
